// File: tb.f
design/isa_pkg.sv
design/apb_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/execute_unit.sv
design/load_store_unit.sv
design/apb_requester.sv
design/core_sequencer.sv
design/rv_core_top.sv
bench/apb_memory.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, fail if the log reports failure
verilator --binary --timing -f tb.f --top-module tb_top -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 &&
! grep -q "test failed" sim.log &&
cat sim.log || {
    cat build.log sim.log 2>/dev/null
    exit 1
}

// File: bench/tb_top.sv
// ==================================================
// testbench for the RV32I core that runs two programs
// and checks every APB store against a table
// ==================================================
module tb_top;
    localparam logic [31:0] start_pc = 32'h0000_0100;
    localparam logic [31:0] bad_addr = 32'h0000_03f0;
    localparam logic [6:0]  op_reg = 7'b0110011, op_imm = 7'b0010011, op_load = 7'b0000011;
    localparam logic [6:0]  op_store = 7'b0100011, op_branch = 7'b1100011, op_lui = 7'b0110111;
    localparam logic [6:0]  op_auipc = 7'b0010111, op_jal = 7'b1101111, op_jalr = 7'b1100111;
    localparam logic [31:0] ebreak_inst = 32'h0010_0073;

    logic              clk = 1'b0;
    logic              reset;
    apb_pkg::apb_req_t apb;
    apb_pkg::apb_rsp_t apb_rsp;
    logic              halted, error;

    logic [31:0] prog1 [$], prog2 [$];
    logic [31:0] exp_addr [$], exp_data [$];
    logic [3:0]  exp_strb [$];
    int          store_idx = 0, xfers = 0, snap, cycles = 0, limit = 100000;
    int          value_errors = 0, other_errors = 0;

    rv_core_top #(.reset_pc(start_pc)) DUT (
        .clk(clk), .reset(reset), .apb(apb), .apb_rsp(apb_rsp),
        .halted(halted), .error(error)
    );

    apb_memory #(.err_addr(bad_addr)) u_mem (
        .clk(clk), .reset(reset), .apb(apb), .apb_rsp(apb_rsp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic expect_store(input logic [31:0] a, d, input logic [3:0] s);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_strb.push_back(s);
    endtask

    task automatic load_program(ref logic [31:0] prog [$]);
        for (int i = 0; i < prog.size(); i++) begin
            u_mem.ram[(start_pc >> 2) + i] = prog[i];
        end
    endtask

    task automatic build_tables;
        prog1 = '{
            itype(12'h300, 0, 0, 10, op_imm),         // x10 = data base
            itype(12'd100, 0, 0, 1, op_imm),
            itype(-12'sd7, 0, 0, 2, op_imm),
            rtype(7'h00, 2, 1, 0, 3), stype(12'd0, 3, 10, 2),   // add
            rtype(7'h20, 2, 1, 0, 4), stype(12'd4, 4, 10, 2),   // sub
            rtype(7'h00, 2, 1, 4, 5), stype(12'd8, 5, 10, 2),   // xor
            itype(12'h401, 2, 5, 6, op_imm), stype(12'd12, 6, 10, 2),
            itype(12'h004, 2, 5, 7, op_imm), stype(12'd16, 7, 10, 2),
            itype(12'h003, 1, 1, 8, op_imm), stype(12'd20, 8, 10, 2),
            rtype(7'h00, 1, 2, 2, 9), rtype(7'h00, 1, 2, 3, 11),
            stype(12'd24, 9, 10, 2), stype(12'd28, 11, 10, 2),
            {20'h12345, 5'd13, op_lui}, stype(12'd32, 13, 10, 2),
            {20'h00001, 5'd14, op_auipc}, stype(12'd36, 14, 10, 2),
            itype(12'h0f0, 2, 7, 15, op_imm), itype(12'h00a, 15, 6, 15, op_imm),
            stype(12'd40, 15, 10, 2),
            itype(12'd0, 0, 0, 16, op_imm), itype(12'd5, 0, 0, 17, op_imm),
            itype(12'd1, 16, 0, 16, op_imm),           // loop body at 0x170
            btype(13'h1ffc, 17, 16, 4),                // blt back
            btype(13'd8, 17, 16, 1),                   // bne not taken
            stype(12'd44, 16, 10, 2),
            jtype(21'd12, 18),                         // jal over two
            itype(-12'sd1, 0, 0, 16, op_imm), stype(12'd44, 16, 10, 2),
            stype(12'd48, 18, 10, 2),
            itype(12'h1a1, 0, 0, 19, op_imm), itype(12'd0, 19, 0, 20, op_jalr),
            stype(12'd0, 0, 10, 2), stype(12'd0, 0, 10, 2),
            stype(12'd52, 20, 10, 2),
            itype(-12'sd123, 0, 0, 21, op_imm),
            stype(12'd57, 21, 10, 0), stype(12'd62, 2, 10, 1),   // sb, sh
            itype(12'd57, 10, 0, 22, op_load), itype(12'd57, 10, 4, 23, op_load),
            itype(12'd62, 10, 1, 24, op_load), itype(12'd62, 10, 5, 25, op_load),
            stype(12'd64, 22, 10, 2), stype(12'd68, 23, 10, 2),
            stype(12'd72, 24, 10, 2), stype(12'd76, 25, 10, 2),
            ebreak_inst
        };
        // second program loads from the error address
        prog2 = '{
            itype(bad_addr[11:0], 0, 0, 1, op_imm),
            itype(12'd0, 1, 2, 2, op_load),
            stype(12'd0, 2, 1, 2),
            ebreak_inst
        };
        expect_store(32'h300, 32'h0000_005d, 4'hf);
        expect_store(32'h304, 32'h0000_006b, 4'hf);
        expect_store(32'h308, 32'hffff_ff9d, 4'hf);
        expect_store(32'h30c, 32'hffff_fffc, 4'hf);
        expect_store(32'h310, 32'h0fff_ffff, 4'hf);
        expect_store(32'h314, 32'h0000_0320, 4'hf);
        expect_store(32'h318, 32'h0000_0001, 4'hf);
        expect_store(32'h31c, 32'h0000_0000, 4'hf);
        expect_store(32'h320, 32'h1234_5000, 4'hf);
        expect_store(32'h324, 32'h0000_1154, 4'hf);
        expect_store(32'h328, 32'h0000_00fa, 4'hf);
        expect_store(32'h32c, 32'h0000_0005, 4'hf);
        expect_store(32'h330, 32'h0000_0184, 4'hf);
        expect_store(32'h334, 32'h0000_0198, 4'hf);
        expect_store(32'h338, 32'h8585_8585, 4'h2);
        expect_store(32'h33c, 32'hfff9_fff9, 4'hc);
        expect_store(32'h340, 32'hffff_ff85, 4'hf);
        expect_store(32'h344, 32'h0000_0085, 4'hf);
        expect_store(32'h348, 32'hffff_fff9, 4'hf);
        expect_store(32'h34c, 32'h0000_fff9, 4'hf);
    endtask

    task automatic check_halt(input logic exp_error, input int exp_stores);
        while (!halted) @(negedge clk);
        assert (error == exp_error) else begin
            value_errors++;
            $display("error: error got %h expected %h", error, exp_error);
        end
        assert (store_idx == exp_stores) else begin
            other_errors++;
            $display("only %0d of %0d expected stores were seen", store_idx, exp_stores);
        end
        snap = xfers;
        repeat (20) @(negedge clk);
        assert (xfers == snap && !apb.psel) else begin
            other_errors++;
            $display("a bus transfer started after the core halted");
        end
    endtask

    task automatic run_reset(input logic [31:0] prog [$]);
        reset = 1'b1;
        load_program(prog);
        repeat (4) @(negedge clk);
        assert (!apb.psel && !halted && !error) else begin
            other_errors++;
            $display("psel, halted or error is high during reset");
        end
        reset = 1'b0;
        repeat (3) begin
            if (!apb.psel) @(negedge clk);
        end
        assert (apb.psel && !apb.penable && apb.paddr == start_pc) else begin
            value_errors++;
            $display("error: paddr got %h expected %h", apb.paddr, start_pc);
        end
    endtask

    // stores are checked when the write completes
    always @(posedge clk) begin
        if (!reset && apb.psel && !apb.penable) begin
            xfers++;
            assert (apb.paddr[1:0] == 2'b00) else begin // fetches and data are word aligned
                value_errors++;
                $display("error: paddr[1:0] got %h expected %h", apb.paddr[1:0], 2'b00);
            end
        end
        if (!reset && apb.psel && apb.penable && apb_rsp.pready && apb.pwrite) begin
            if (store_idx < exp_addr.size()) begin
                assert (apb.paddr == exp_addr[store_idx]) else begin
                    value_errors++;
                    $display("error: paddr got %h expected %h", apb.paddr, exp_addr[store_idx]);
                end
                assert (apb.pwdata == exp_data[store_idx]) else begin
                    value_errors++;
                    $display("error: pwdata got %h expected %h", apb.pwdata,
                             exp_data[store_idx]);
                end
                assert (apb.pstrb == exp_strb[store_idx]) else begin
                    value_errors++;
                    $display("error: pstrb got %h expected %h", apb.pstrb, exp_strb[store_idx]);
                end
            end else begin
                other_errors++;
                $display("unexpected store to address %h", apb.paddr);
            end
            store_idx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        reset   = 1'b1;
        build_tables();
        limit = 40 * (prog1.size() + prog2.size()) + 100;
        run_reset(prog1);
        check_halt(1'b0, exp_addr.size());
        @(negedge clk);
        run_reset(prog2);
        check_halt(1'b1, exp_addr.size());
        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: bench/apb_memory.sv
// ==================================================
// 1 KiB APB4 completer memory for the testbench
// with random wait states and one slave-error address
// ==================================================
module apb_memory #(
    parameter logic [31:0] err_addr = 32'h0000_03f0
) (
    input  logic              clk,
    input  logic              reset,
    input  apb_pkg::apb_req_t apb,
    output apb_pkg::apb_rsp_t apb_rsp
);
    logic [31:0] ram [0:255];
    logic [31:0] lfsr;
    logic [1:0]  waits;
    logic        bit0, bit1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    initial begin
        lfsr = 32'h3942;
        for (int i = 0; i < 256; i++) begin
            ram[i] = 32'hc0de_0000 ^ (i << 2); // low half holds the byte address
        end
    end

    // responses change on the falling edge
    always @(negedge clk or posedge reset) begin
        if (reset) begin
            apb_rsp <= '0;
            waits   <= 2'd0;
        end else begin
            apb_rsp.pready  <= 1'b0;
            apb_rsp.pslverr <= 1'b0;
            if (apb.psel && !apb.penable) begin
                bit0 = lfsr[0];
                lfsr = lfsr_next(lfsr);
                bit1 = lfsr[0];
                lfsr = lfsr_next(lfsr);
                waits <= {bit1, bit0} % 2'd3; // 0 to 2 wait states
            end else if (apb.psel && apb.penable && !apb_rsp.pready) begin
                if (waits != 2'd0) begin
                    waits <= waits - 2'd1;
                end else begin
                    apb_rsp.pready <= 1'b1;
                    if (apb.paddr == err_addr) begin
                        apb_rsp.pslverr <= 1'b1;
                    end else if (apb.pwrite) begin
                        for (int b = 0; b < 4; b++) begin
                            if (apb.pstrb[b]) begin
                                ram[apb.paddr[9:2]][b*8 +: 8] <= apb.pwdata[b*8 +: 8];
                            end
                        end
                    end else begin
                        apb_rsp.prdata <= ram[apb.paddr[9:2]];
                    end
                end
            end
        end
    end

endmodule

// File: design/rv_core_top.sv
// ==================================================
// multi-cycle RV32I core with one shared APB4 port
// ==================================================
module rv_core_top #(
    parameter logic [isa_pkg::xlen-1:0] reset_pc = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              reset,
    output apb_pkg::apb_req_t apb,
    input  apb_pkg::apb_rsp_t apb_rsp,
    output logic              halted,
    output logic              error
);
    isa_pkg::decoded_t        dec;
    apb_pkg::bus_cmd_t        cmd, data_cmd;
    logic                     start, done, slverr, wb_en, jump_taken;
    logic [isa_pkg::xlen-1:0] rdata, inst, pc, load_word, load_data;
    logic [isa_pkg::xlen-1:0] rs1_data, rs2_data, alu_result, jump_target, wb_data;

    core_sequencer #(.reset_pc(reset_pc)) u_seq (
        .clk(clk), .reset(reset), .dec(dec),
        .jump_taken(jump_taken), .jump_target(jump_target), .data_cmd(data_cmd),
        .done(done), .rdata(rdata), .slverr(slverr),
        .cmd(cmd), .start(start), .inst(inst), .pc(pc), .wb_en(wb_en),
        .load_word(load_word), .halted(halted), .error(error)
    );

    inst_decoder u_dec (.inst(inst), .dec(dec));

    reg_file u_regs (
        .clk(clk), .reset(reset), .dec(dec), .wb_en(wb_en), .wb_data(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_unit u_exe (
        .dec(dec), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .load_data(load_data), .alu_result(alu_result), .jump_taken(jump_taken),
        .jump_target(jump_target), .wb_data(wb_data)
    );

    load_store_unit u_lsu (
        .dec(dec), .alu_result(alu_result), .rs2_data(rs2_data),
        .load_word(load_word), .data_cmd(data_cmd), .load_data(load_data)
    );

    apb_requester u_apb (
        .clk(clk), .reset(reset), .cmd(cmd), .start(start), .apb(apb),
        .apb_rsp(apb_rsp), .done(done), .rdata(rdata), .slverr(slverr)
    );

endmodule

// File: design/core_sequencer.sv
// ==================================================
// steps one instruction at a time through fetch,
// execute, memory and writeback; owns pc and halt
// ==================================================
module core_sequencer #(
    parameter logic [isa_pkg::xlen-1:0] reset_pc = 32'h0000_0000
) (
    input  logic                     clk,
    input  logic                     reset,
    input  isa_pkg::decoded_t        dec,
    input  logic                     jump_taken,
    input  logic [isa_pkg::xlen-1:0] jump_target,
    input  apb_pkg::bus_cmd_t        data_cmd,
    input  logic                     done,
    input  logic [isa_pkg::xlen-1:0] rdata,
    input  logic                     slverr,
    output apb_pkg::bus_cmd_t        cmd,
    output logic                     start,
    output logic [isa_pkg::xlen-1:0] inst,
    output logic [isa_pkg::xlen-1:0] pc,
    output logic                     wb_en,
    output logic [isa_pkg::xlen-1:0] load_word,
    output logic                     halted,
    output logic                     error
);
    typedef enum logic [2:0] {FETCH, EXECUTE, MEMORY, WRITEBACK, HALT} state_e;

    state_e state, state_next;
    logic   err_set;

    always_comb begin
        state_next = state;
        err_set    = 1'b0;
        case (state)
            FETCH, MEMORY: begin
                if (done && slverr) begin
                    state_next = HALT;
                    err_set    = 1'b1;
                end else if (done) begin
                    state_next = (state == FETCH) ? EXECUTE : WRITEBACK;
                end
            end
            EXECUTE: begin
                if (dec.ebreak) begin
                    state_next = HALT;
                end else if (dec.illegal) begin
                    state_next = HALT;
                    err_set    = 1'b1;
                end else if (dec.opcode == isa_pkg::OPC_LOAD ||
                             dec.opcode == isa_pkg::OPC_STORE) begin
                    state_next = MEMORY;
                end else begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: state_next = FETCH;
            default:   state_next = HALT; // stays until reset
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            start <= 1'b1; // first fetch right out of reset
            pc    <= reset_pc;
            error <= 1'b0;
        end else begin
            state <= state_next;
            start <= (state_next != state) &&
                     (state_next == FETCH || state_next == MEMORY);
            error <= error | err_set;
            if (state == WRITEBACK) begin
                pc <= jump_taken ? jump_target : pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done && state == FETCH) begin
            inst <= rdata;
        end
        if (done && state == MEMORY) begin
            load_word <= rdata;
        end
    end

    // fetch is a full-word read at pc
    assign cmd = (state == FETCH) ?
                 '{write: 1'b0, addr: pc, wdata: '0, strb: 4'hf} : data_cmd;

    assign wb_en  = (state == WRITEBACK) && (dec.wb_src != isa_pkg::WB_NONE);
    assign halted = (state == HALT);

endmodule

// File: design/apb_requester.sv
// ==================================================
// APB4 requester, one SETUP/ACCESS transfer per start
// ==================================================
module apb_requester (
    input  logic                     clk,
    input  logic                     reset,
    input  apb_pkg::bus_cmd_t        cmd,
    input  logic                     start,
    output apb_pkg::apb_req_t        apb,
    input  apb_pkg::apb_rsp_t        apb_rsp,
    output logic                     done,
    output logic [isa_pkg::xlen-1:0] rdata,
    output logic                     slverr
);
    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_e;

    state_e            state;
    apb_pkg::bus_cmd_t cmd_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (start) state <= SETUP;
                SETUP:   state <= ACCESS;
                default: if (apb_rsp.pready) state <= IDLE; // wait states stretch access
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == IDLE) begin
            cmd_q <= cmd; // held stable for the whole transfer
        end
    end

    assign apb.psel    = (state != IDLE);
    assign apb.penable = (state == ACCESS);
    assign apb.pwrite  = cmd_q.write;
    assign apb.paddr   = cmd_q.addr;
    assign apb.pwdata  = cmd_q.wdata;
    assign apb.pstrb   = cmd_q.strb;

    assign done   = (state == ACCESS) && apb_rsp.pready;
    assign rdata  = apb_rsp.prdata;
    assign slverr = apb_rsp.pslverr;

endmodule

// File: design/load_store_unit.sv
// ==================================================
// data bus command with byte lanes, load extension
// ==================================================
module load_store_unit (
    input  isa_pkg::decoded_t        dec,
    input  logic [isa_pkg::xlen-1:0] alu_result,
    input  logic [isa_pkg::xlen-1:0] rs2_data,
    input  logic [isa_pkg::xlen-1:0] load_word,
    output apb_pkg::bus_cmd_t        data_cmd,
    output logic [isa_pkg::xlen-1:0] load_data
);
    logic [1:0]               offset;
    logic [isa_pkg::xlen-1:0] shifted;

    assign offset = alu_result[1:0];

    always_comb begin
        data_cmd.write = (dec.opcode == isa_pkg::OPC_STORE);
        data_cmd.addr  = {alu_result[isa_pkg::xlen-1:2], 2'b00}; // word aligned
        case (dec.funct3[1:0])
            2'b00:   {data_cmd.wdata, data_cmd.strb} = {{4{rs2_data[7:0]}}, 4'b0001 << offset};
            2'b01:   {data_cmd.wdata, data_cmd.strb} = {{2{rs2_data[15:0]}}, 4'b0011 << offset};
            default: {data_cmd.wdata, data_cmd.strb} = {rs2_data, 4'b1111};
        endcase
    end

    assign shifted = load_word >> {offset, 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};   // lb
            3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]}; // lh
            3'b100:  load_data = {24'b0, shifted[7:0]};
            3'b101:  load_data = {16'b0, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

endmodule

// File: design/execute_unit.sv
// ==================================================
// ALU with operand select, branch compare, jump
// target and writeback value
// ==================================================
module execute_unit (
    input  isa_pkg::decoded_t        dec,
    input  logic [isa_pkg::xlen-1:0] pc,
    input  logic [isa_pkg::xlen-1:0] rs1_data,
    input  logic [isa_pkg::xlen-1:0] rs2_data,
    input  logic [isa_pkg::xlen-1:0] load_data,
    output logic [isa_pkg::xlen-1:0] alu_result,
    output logic                     jump_taken,
    output logic [isa_pkg::xlen-1:0] jump_target,
    output logic [isa_pkg::xlen-1:0] wb_data
);
    logic [isa_pkg::xlen-1:0] a, b, link;
    logic                     branch_hit;

    always_comb begin
        case (dec.fmt)
            isa_pkg::FMT_I, isa_pkg::FMT_S: {a, b} = {rs1_data, dec.imm};
            isa_pkg::FMT_U: begin
                a = (dec.opcode == isa_pkg::OPC_LUI) ? '0 : pc;
                b = dec.imm;
            end
            isa_pkg::FMT_B, isa_pkg::FMT_J: {a, b} = {pc, dec.imm};
            default: {a, b} = {rs1_data, rs2_data};
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            isa_pkg::ALU_SUB:  alu_result = a - b;
            isa_pkg::ALU_SLL:  alu_result = a << b[4:0];
            isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(a) < $signed(b)};
            isa_pkg::ALU_SLTU: alu_result = {31'b0, a < b};
            isa_pkg::ALU_XOR:  alu_result = a ^ b;
            isa_pkg::ALU_SRL:  alu_result = a >> b[4:0];
            isa_pkg::ALU_SRA:  alu_result = $unsigned($signed(a) >>> b[4:0]);
            isa_pkg::ALU_OR:   alu_result = a | b;
            isa_pkg::ALU_AND:  alu_result = a & b;
            default:           alu_result = a + b;
        endcase
    end

    // branch compare uses the register operands, not a/b
    always_comb begin
        case (dec.funct3)
            3'b000:  branch_hit = (rs1_data == rs2_data);
            3'b001:  branch_hit = (rs1_data != rs2_data);
            3'b100:  branch_hit = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  branch_hit = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  branch_hit = (rs1_data < rs2_data);
            3'b111:  branch_hit = (rs1_data >= rs2_data);
            default: branch_hit = 1'b0;
        endcase
    end

    assign jump_taken  = (dec.opcode == isa_pkg::OPC_JAL) || (dec.opcode == isa_pkg::OPC_JALR) ||
                         (dec.opcode == isa_pkg::OPC_BRANCH && branch_hit);
    assign jump_target = (dec.opcode == isa_pkg::OPC_JALR) ?
                         {alu_result[isa_pkg::xlen-1:1], 1'b0} : alu_result;
    assign link        = pc + 32'd4;

    always_comb begin
        case (dec.wb_src)
            isa_pkg::WB_LINK: wb_data = link;
            isa_pkg::WB_LOAD: wb_data = load_data;
            default:          wb_data = alu_result;
        endcase
    end

endmodule

// File: design/reg_file.sv
// ==================================================
// integer registers x1..x31, x0 reads as zero
// ==================================================
module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  isa_pkg::decoded_t        dec,
    input  logic                     wb_en,
    input  logic [isa_pkg::xlen-1:0] wb_data,
    output logic [isa_pkg::xlen-1:0] rs1_data,
    output logic [isa_pkg::xlen-1:0] rs2_data
);
    logic [isa_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && dec.rd != 5'd0) begin
            regs[dec.rd] <= wb_data;
        end
    end

    assign rs1_data = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

endmodule

// File: design/inst_decoder.sv
// ==================================================
// RV32I decode: fields, format, immediate, ALU op
// ==================================================
module inst_decoder (
    input  logic [isa_pkg::xlen-1:0] inst,
    output isa_pkg::decoded_t        dec
);
    logic [6:0] funct7;

    assign funct7 = inst[31:25];

    always_comb begin
        dec.opcode  = isa_pkg::opcode_e'(inst[6:0]);
        dec.funct3  = inst[14:12];
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.ebreak  = (inst == 32'h0010_0073);
        dec.illegal = 1'b0;
        dec.fmt     = isa_pkg::FMT_N;
        dec.wb_src  = isa_pkg::WB_NONE;
        case (dec.opcode)
            isa_pkg::OPC_OP:     {dec.fmt, dec.wb_src} = {isa_pkg::FMT_R, isa_pkg::WB_ALU};
            isa_pkg::OPC_OP_IMM: {dec.fmt, dec.wb_src} = {isa_pkg::FMT_I, isa_pkg::WB_ALU};
            isa_pkg::OPC_LOAD:   {dec.fmt, dec.wb_src} = {isa_pkg::FMT_I, isa_pkg::WB_LOAD};
            isa_pkg::OPC_JALR:   {dec.fmt, dec.wb_src} = {isa_pkg::FMT_I, isa_pkg::WB_LINK};
            isa_pkg::OPC_STORE:  dec.fmt = isa_pkg::FMT_S;
            isa_pkg::OPC_BRANCH: dec.fmt = isa_pkg::FMT_B;
            isa_pkg::OPC_LUI,
            isa_pkg::OPC_AUIPC:  {dec.fmt, dec.wb_src} = {isa_pkg::FMT_U, isa_pkg::WB_ALU};
            isa_pkg::OPC_JAL:    {dec.fmt, dec.wb_src} = {isa_pkg::FMT_J, isa_pkg::WB_LINK};
            isa_pkg::OPC_SYSTEM: dec.illegal = !dec.ebreak; // only ebreak kept
            default:             dec.illegal = 1'b1;
        endcase

        case (dec.fmt)
            isa_pkg::FMT_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            isa_pkg::FMT_S: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            isa_pkg::FMT_B: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            isa_pkg::FMT_U: dec.imm = {inst[31:12], 12'b0};
            isa_pkg::FMT_J: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:        dec.imm = '0;
        endcase

        dec.alu_op = isa_pkg::ALU_ADD; // address and link arithmetic
        if (dec.opcode == isa_pkg::OPC_OP || dec.opcode == isa_pkg::OPC_OP_IMM) begin
            case (dec.funct3)
                3'b000: if (dec.opcode == isa_pkg::OPC_OP && funct7[5]) begin
                    dec.alu_op = isa_pkg::ALU_SUB;
                end
                3'b001:  dec.alu_op = isa_pkg::ALU_SLL;
                3'b010:  dec.alu_op = isa_pkg::ALU_SLT;
                3'b011:  dec.alu_op = isa_pkg::ALU_SLTU;
                3'b100:  dec.alu_op = isa_pkg::ALU_XOR;
                3'b101:  dec.alu_op = funct7[5] ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
                3'b110:  dec.alu_op = isa_pkg::ALU_OR;
                default: dec.alu_op = isa_pkg::ALU_AND;
            endcase
        end
    end

endmodule

// File: design/apb_pkg.sv
// ==================================================
// APB4 requester/completer signal bundles and the
// internal one-transfer bus command
// ==================================================
package apb_pkg;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [isa_pkg::xlen-1:0] paddr;
        logic [isa_pkg::xlen-1:0] pwdata;
        logic [3:0]               pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                     pready;
        logic [isa_pkg::xlen-1:0] prdata;
        logic                     pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                     write;
        logic [isa_pkg::xlen-1:0] addr;
        logic [isa_pkg::xlen-1:0] wdata;
        logic [3:0]               strb;
    } bus_cmd_t;

endpackage

// File: design/isa_pkg.sv
// ==================================================
// RV32I encodings and decoded-instruction type
// shared by the decoder, execute and sequencer
// ==================================================
package isa_pkg;

    parameter int xlen = 32;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_N} inst_fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LINK, WB_LOAD} wb_src_e;

    typedef struct packed {
        opcode_e         opcode;
        inst_fmt_e       fmt;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
        alu_op_e         alu_op;
        wb_src_e         wb_src;
        logic            illegal;
        logic            ebreak;
    } decoded_t;

endpackage
